// ==== filelist.f ====
rtl/tag_cmp_pkg.sv
rtl/req_arbiter.sv
rtl/way_check.sv
rtl/ecc_err_counter.sv
rtl/tag_cmp_top.sv
tb/tag_cmp_props.sv
tb/tb_tag_cmp.sv

// ==== Bender.yml ====
package:
  name: tag_cmp

sources:
  - rtl/tag_cmp_pkg.sv
  - rtl/req_arbiter.sv
  - rtl/way_check.sv
  - rtl/ecc_err_counter.sv
  - rtl/tag_cmp_top.sv
  - target: test
    files:
      - tb/tag_cmp_props.sv
      - tb/tb_tag_cmp.sv

// ==== tb/tb_tag_cmp.sv ====
`timescale 1ns/100ps

module tb_tag_cmp import tag_cmp_pkg::*; ();

  localparam int ClkPeriod = 8;
  localparam int NumRows   = 14;
  // marks an unused fault bit
  localparam logic [6:0] NoFlip = 7'h7f;

  typedef enum logic [1:0] {
    OpWrite,
    OpPartial,
    OpRead,
    OpPrio
  } op_e;

  typedef struct packed {
    op_e                   op;
    logic                  port;
    logic [NumWays-1:0]    ways;
    logic [IndexWidth-1:0] index;
    logic [TagWidth-1:0]   tag;
    logic [7:0]            be;
    logic [6:0]            flip_a;
    logic [6:0]            flip_b;
    logic [NumWays-1:0]    exp_hit;
    logic                  chk_data;
    ecc_err_t              err_inc;
    logic                  exp_pulse;
  } row_t;

  logic                              clk_i;
  logic                              rst_ni;
  port_req_t [NumPorts-1:0]          req_i;
  logic [NumPorts-1:0][TagWidth-1:0] tag_i;
  sram_line_t [NumWays-1:0]          rdata_i;
  logic [NumPorts-1:0]               gnt_o;
  sram_req_t                         sram_req_o;
  line_t [NumWays-1:0]               rdata_o;
  logic [NumWays-1:0]                hit_way_o;
  err_count_t                        err_count_o;
  logic                              error_inc_o;

  row_t       rows [NumRows];
  sram_line_t mem [1 << IndexWidth][NumWays];
  line_t      ref_mem [1 << IndexWidth][NumWays];
  err_count_t exp_cnt;
  logic [31:0] lfsr_q;

  tag_cmp_top i_dut (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .req_i       (req_i),
    .tag_i       (tag_i),
    .rdata_i     (rdata_i),
    .gnt_o       (gnt_o),
    .sram_req_o  (sram_req_o),
    .rdata_o     (rdata_o),
    .hit_way_o   (hit_way_o),
    .err_count_o (err_count_o),
    .error_inc_o (error_inc_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(ClkPeriod * (NumRows * 10 + 8));
    $display("timeout, the test sequence did not finish in time");
    $display("TEST RESULT: FAIL");
    $fatal(1, "watchdog expired");
  end

  // --------------------------------------------------
  // behavioral sram with one cycle of read latency
  // --------------------------------------------------
  always @(posedge clk_i) begin
    for (int w = 0; w < NumWays; w++) begin
      if (sram_req_o.req[w] && !sram_req_o.we) begin
        rdata_i[w] <= mem[sram_req_o.index][w];
      end else begin
        rdata_i[w] <= '0;
      end
      if (sram_req_o.req[w] && sram_req_o.we) begin
        if (sram_req_o.be_tag) begin
          mem[sram_req_o.index][w].valid = sram_req_o.wdata.valid;
          mem[sram_req_o.index][w].tag   = sram_req_o.wdata.tag;
        end
        for (int b = 0; b < NumBlocks; b++) begin
          if (sram_req_o.be_data[b]) begin
            mem[sram_req_o.index][w].data[b] = sram_req_o.wdata.data[b];
          end
        end
      end
    end
  end

  // --------------------------------------------------
  // helpers
  // --------------------------------------------------
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic next_bits(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_step(lfsr_q);
      v      = {v[62:0], lfsr_q[0]};
    end
  endtask

  function automatic row_t make_row(
    input op_e                   op,
    input logic                  port,
    input logic [NumWays-1:0]    ways,
    input logic [IndexWidth-1:0] index,
    input logic [TagWidth-1:0]   tag,
    input logic [7:0]            be,
    input logic [6:0]            flip_a,
    input logic [6:0]            flip_b,
    input logic [NumWays-1:0]    exp_hit,
    input logic                  chk_data,
    input logic [3:0]            err_inc,
    input logic                  exp_pulse
  );
    row_t r;
    r = '{op, port, ways, index, tag, be, flip_a, flip_b, exp_hit, chk_data,
          ecc_err_t'(err_inc), exp_pulse};
    return r;
  endfunction

  function automatic port_req_t build_req(
    input logic [NumWays-1:0]    ways,
    input logic [IndexWidth-1:0] index,
    input logic                  we,
    input line_t                 wdata,
    input line_be_t              be
  );
    port_req_t r;
    r.req   = ways;
    r.index = index;
    r.we    = we;
    r.wdata = wdata;
    r.be    = be;
    return r;
  endfunction

  // every write in this sequence covers all blocks and the tag
  function automatic sram_req_t sram_ctl(
    input logic [NumWays-1:0]    ways,
    input logic [IndexWidth-1:0] index,
    input logic                  we
  );
    sram_req_t s;
    s         = '0;
    s.req     = ways;
    s.index   = index;
    s.we      = we;
    s.be_data = {NumBlocks{we}};
    s.be_tag  = we;
    return s;
  endfunction

  function automatic int first_way(input logic [NumWays-1:0] m);
    for (int w = 0; w < NumWays; w++) begin
      if (m[w]) return w;
    end
    return 0;
  endfunction

  task automatic fail_now(input string msg);
    $display("%s", msg);
    $display("TEST RESULT: FAIL");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_line(input string name, input line_t got, input line_t exp);
    if (got !== exp) fail_now($sformatf("[ERROR] %s got %h expected %h", name, got, exp));
  endtask

  task automatic check_hit(input logic [NumWays-1:0] got, input logic [NumWays-1:0] exp);
    if (got !== exp) fail_now($sformatf("[ERROR] hit_way_o got %h expected %h", got, exp));
  endtask

  task automatic check_counts(input err_count_t got, input err_count_t exp);
    if (got !== exp) fail_now($sformatf("[ERROR] err_count_o got %h expected %h", got, exp));
  endtask

  task automatic check_gnt(input logic [NumPorts-1:0] got, input logic [NumPorts-1:0] exp);
    if (got !== exp) fail_now($sformatf("[ERROR] gnt_o got %h expected %h", got, exp));
  endtask

  task automatic check_pulse(input logic got, input logic exp);
    if (got !== exp) fail_now($sformatf("[ERROR] error_inc_o got %h expected %h", got, exp));
  endtask

  // write data is checked through later reads
  task automatic check_sram_req(input sram_req_t got, input sram_req_t exp);
    sram_req_t ctl;
    ctl       = got;
    ctl.wdata = '0;
    if (!got.we) begin
      ctl.be_data = '0;
      ctl.be_tag  = 1'b0;
    end
    if (ctl !== exp) fail_now($sformatf("[ERROR] sram_req_o got %h expected %h", ctl, exp));
  endtask

  // flipping twice restores the stored word
  task automatic toggle_faults(input row_t r);
    int w;
    w = first_way(r.ways);
    if (r.flip_a != NoFlip) mem[r.index][w][r.flip_a] = ~mem[r.index][w][r.flip_a];
    if (r.flip_b != NoFlip) mem[r.index][w][r.flip_b] = ~mem[r.index][w][r.flip_b];
  endtask

  task automatic check_read_result(input row_t r);
    int hw;
    hw = first_way(r.exp_hit);
    check_hit(hit_way_o, r.exp_hit);
    check_pulse(error_inc_o, r.exp_pulse);
    if (r.chk_data && r.exp_hit != '0) check_line("rdata_o", rdata_o[hw], ref_mem[r.index][hw]);
  endtask

  task automatic add_expected(input ecc_err_t inc);
    exp_cnt.tag_ce  = exp_cnt.tag_ce + inc.tag_ce;
    exp_cnt.tag_ue  = exp_cnt.tag_ue + inc.tag_ue;
    exp_cnt.data_ce = exp_cnt.data_ce + inc.data_ce;
    exp_cnt.data_ue = exp_cnt.data_ue + inc.data_ue;
  endtask

  // --------------------------------------------------
  // row sequences
  // --------------------------------------------------
  task automatic run_write(input row_t r);
    logic [63:0] rnd;
    line_t       wl;
    line_be_t    be;
    int          w;
    next_bits(64, rnd);
    w        = first_way(r.ways);
    wl.valid = 1'b1;
    wl.tag   = r.tag;
    wl.data  = rnd;
    be.tag   = (r.op == OpWrite);
    be.data  = (r.op == OpWrite) ? 8'hff : r.be;
    @(posedge clk_i);
    req_i[r.port] <= build_req(r.ways, r.index, 1'b1, wl, be);
    @(negedge clk_i);
    if (r.op == OpPartial) begin
      check_gnt(gnt_o, '0);
      check_sram_req(sram_req_o, sram_ctl(r.ways, r.index, 1'b0));
      @(posedge clk_i);
      @(negedge clk_i);
    end
    check_gnt(gnt_o, NumPorts'(1) << r.port);
    check_sram_req(sram_req_o, sram_ctl(r.ways, r.index, 1'b1));
    @(posedge clk_i);
    req_i[r.port] <= '0;
    if (r.op == OpWrite) begin
      ref_mem[r.index][w] = wl;
    end else begin
      for (int k = 0; k < 8; k++) begin
        if (r.be[k]) ref_mem[r.index][w].data[k*8 +: 8] = rnd[k*8 +: 8];
      end
    end
  endtask

  task automatic run_read(input row_t r);
    @(negedge clk_i);
    toggle_faults(r);
    @(posedge clk_i);
    req_i[r.port] <= build_req(r.ways, r.index, 1'b0, '0, '0);
    @(negedge clk_i);
    check_gnt(gnt_o, NumPorts'(1) << r.port);
    check_sram_req(sram_req_o, sram_ctl(r.ways, r.index, 1'b0));
    @(posedge clk_i);
    req_i[r.port] <= '0;
    tag_i[r.port] <= r.tag;
    @(negedge clk_i);
    check_read_result(r);
    add_expected(r.err_inc);
    @(negedge clk_i);
    check_counts(err_count_o, exp_cnt);
    toggle_faults(r);
  endtask

  // both ports read the same set and port 0 wins first
  task automatic run_prio(input row_t r);
    @(posedge clk_i);
    req_i[0] <= build_req(r.ways, r.index, 1'b0, '0, '0);
    req_i[1] <= build_req(r.ways, r.index, 1'b0, '0, '0);
    @(negedge clk_i);
    check_gnt(gnt_o, 2'b01);
    check_sram_req(sram_req_o, sram_ctl(r.ways, r.index, 1'b0));
    @(posedge clk_i);
    req_i[0] <= '0;
    tag_i[0] <= r.tag;
    @(negedge clk_i);
    check_gnt(gnt_o, 2'b10);
    check_sram_req(sram_req_o, sram_ctl(r.ways, r.index, 1'b0));
    check_read_result(r);
    @(posedge clk_i);
    req_i[1] <= '0;
    tag_i[1] <= r.tag;
    @(negedge clk_i);
    check_gnt(gnt_o, 2'b00);
    check_read_result(r);
    @(negedge clk_i);
    check_counts(err_count_o, exp_cnt);
  endtask

  // --------------------------------------------------
  // stimulus table and main sequence
  // --------------------------------------------------
  initial begin
    rows[0]  = make_row(OpWrite,   0, 4'b0001, 3, 20'h1_a2b3, 8'hff, NoFlip, NoFlip,
                        4'b0000, 0, 4'b0000, 0);
    rows[1]  = make_row(OpWrite,   1, 4'b0100, 3, 20'h4_c5d6, 8'hff, NoFlip, NoFlip,
                        4'b0000, 0, 4'b0000, 0);
    rows[2]  = make_row(OpRead,    0, 4'b1111, 3, 20'h1_a2b3, 8'h00, NoFlip, NoFlip,
                        4'b0001, 1, 4'b0000, 0);
    rows[3]  = make_row(OpRead,    1, 4'b1111, 3, 20'h4_c5d6, 8'h00, NoFlip, NoFlip,
                        4'b0100, 1, 4'b0000, 0);
    rows[4]  = make_row(OpRead,    0, 4'b1111, 3, 20'h7_0e0f, 8'h00, NoFlip, NoFlip,
                        4'b0000, 0, 4'b0000, 0);
    rows[5]  = make_row(OpPrio,    0, 4'b1111, 3, 20'h1_a2b3, 8'h00, NoFlip, NoFlip,
                        4'b0001, 1, 4'b0000, 0);
    rows[6]  = make_row(OpWrite,   0, 4'b0010, 5, 20'h9_8765, 8'hff, NoFlip, NoFlip,
                        4'b0000, 0, 4'b0000, 0);
    rows[7]  = make_row(OpPartial, 1, 4'b0010, 5, 20'h9_8765, 8'h69, NoFlip, NoFlip,
                        4'b0000, 0, 4'b0000, 0);
    rows[8]  = make_row(OpRead,    0, 4'b0010, 5, 20'h9_8765, 8'h00, NoFlip, NoFlip,
                        4'b0010, 1, 4'b0000, 0);
    // tag_ce, tag_ue, data_ce, data_ue
    rows[9]  = make_row(OpRead,    0, 4'b0001, 3, 20'h1_a2b3, 8'h00, 7'd83, NoFlip,
                        4'b0001, 1, 4'b1000, 0);
    rows[10] = make_row(OpRead,    1, 4'b0100, 3, 20'h4_c5d6, 8'h00, 7'd50, NoFlip,
                        4'b0100, 1, 4'b0010, 0);
    rows[11] = make_row(OpRead,    0, 4'b0001, 3, 20'h1_a2b3, 8'h00, 7'd10, 7'd20,
                        4'b0001, 0, 4'b0001, 1);
    rows[12] = make_row(OpRead,    0, 4'b0100, 3, 20'h4_c5d6, 8'h00, 7'd80, 7'd90,
                        4'b0000, 0, 4'b0100, 1);
    rows[13] = make_row(OpRead,    0, 4'b0001, 3, 20'h1_a2b3, 8'h00, NoFlip, NoFlip,
                        4'b0001, 1, 4'b0000, 0);

    lfsr_q  = 32'h0b08_75b4;
    exp_cnt = '0;
    req_i   = '0;
    tag_i   = '0;
    rdata_i = '0;
    rst_ni  = 1'b0;
    for (int i = 0; i < (1 << IndexWidth); i++) begin
      for (int w = 0; w < NumWays; w++) begin
        mem[i][w]     = '0;
        ref_mem[i][w] = '0;
      end
    end
    repeat (4) @(posedge clk_i);
    rst_ni <= 1'b1;

    for (int r = 0; r < NumRows; r++) begin
      case (rows[r].op)
        OpWrite, OpPartial: run_write(rows[r]);
        OpRead:             run_read(rows[r]);
        default:            run_prio(rows[r]);
      endcase
    end

    repeat (2) @(posedge clk_i);
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

// ==== tb/tag_cmp_props.sv ====
`timescale 1ns/100ps

module tag_cmp_props import tag_cmp_pkg::*; (
  input logic                     clk_i,
  input logic                     rst_ni,
  input port_req_t [NumPorts-1:0] req_i,
  input logic [NumPorts-1:0]      gnt_o,
  input logic [NumWays-1:0]       hit_way_o
);

  logic [NumPorts-1:0] req_any;
  logic [NumPorts-1:0] partial;

  // mixed byte enables inside one block make a partial write
  always_comb begin
    logic [BytesPerBlock-1:0] blk_be;
    for (int p = 0; p < NumPorts; p++) begin
      req_any[p] = |req_i[p].req;
      partial[p] = 1'b0;
      for (int b = 0; b < NumBlocks; b++) begin
        blk_be = req_i[p].be.data[b*BytesPerBlock +: BytesPerBlock];
        if (blk_be != '0 && blk_be != '1) partial[p] = 1'b1;
      end
      partial[p] = partial[p] & req_i[p].we & req_any[p];
    end
  end

  hit_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(hit_way_o))
    else $error("more than one way hit");

  gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni) $onehot0(gnt_o))
    else $error("more than one port granted");

  for (genvar p = 0; p < NumPorts; p++) begin : g_port
    // partial write grant needs an ungranted request one cycle before
    partial_late: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (gnt_o[p] && partial[p]) |-> $past(req_any[p] && !gnt_o[p]))
      else $error("partial write granted in its first cycle");
  end

endmodule

bind tag_cmp_top tag_cmp_props i_props (
  .clk_i     (clk_i),
  .rst_ni    (rst_ni),
  .req_i     (req_i),
  .gnt_o     (gnt_o),
  .hit_way_o (hit_way_o)
);

// ==== rtl/tag_cmp_top.sv ====
`timescale 1ns/100ps

module tag_cmp_top import tag_cmp_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  port_req_t [NumPorts-1:0]          req_i,
  input  logic [NumPorts-1:0][TagWidth-1:0] tag_i,
  input  sram_line_t [NumWays-1:0]          rdata_i,
  output logic [NumPorts-1:0]               gnt_o,
  output sram_req_t                         sram_req_o,
  output line_t [NumWays-1:0]               rdata_o,
  output logic [NumWays-1:0]                hit_way_o,
  output err_count_t                        err_count_o,
  output logic                              error_inc_o
);

  logic [TagWidth-1:0]    sel_tag;
  ecc_err_t [NumWays-1:0] way_err;

  // --------------------------------------------------
  // arbitration and write path
  // --------------------------------------------------
  req_arbiter i_arbiter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .req_i      (req_i),
    .tag_i      (tag_i),
    .loaded_i   (rdata_o),
    .gnt_o      (gnt_o),
    .sram_req_o (sram_req_o),
    .sel_tag_o  (sel_tag)
  );

  // --------------------------------------------------
  // per-way decode and compare
  // --------------------------------------------------
  for (genvar w = 0; w < NumWays; w++) begin : g_way
    way_check i_way_check (
      .rd_line_i (rdata_i[w]),
      .sel_tag_i (sel_tag),
      .line_o    (rdata_o[w]),
      .hit_o     (hit_way_o[w]),
      .err_o     (way_err[w])
    );
  end

  // error statistics
  ecc_err_counter i_err_counter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .err_i       (way_err),
    .err_count_o (err_count_o),
    .error_inc_o (error_inc_o)
  );

endmodule

// ==== rtl/ecc_err_counter.sv ====
`timescale 1ns/100ps

module ecc_err_counter import tag_cmp_pkg::*; (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  ecc_err_t [NumWays-1:0] err_i,
  output err_count_t             err_count_o,
  output logic                   error_inc_o
);

  ecc_err_t   any_err;
  err_count_t count_d, count_q;

  // one event per kind and cycle, however many ways report it
  always_comb begin
    any_err = '0;
    for (int w = 0; w < NumWays; w++) begin
      any_err.tag_ce  = any_err.tag_ce  | err_i[w].tag_ce;
      any_err.tag_ue  = any_err.tag_ue  | err_i[w].tag_ue;
      any_err.data_ce = any_err.data_ce | err_i[w].data_ce;
      any_err.data_ue = any_err.data_ue | err_i[w].data_ue;
    end
  end

  // --------------------------------------------------
  // counters
  // --------------------------------------------------
  always_comb begin
    count_d = count_q;
    if (any_err.tag_ce)  count_d.tag_ce  = count_q.tag_ce  + CountWidth'(1);
    if (any_err.tag_ue)  count_d.tag_ue  = count_q.tag_ue  + CountWidth'(1);
    if (any_err.data_ce) count_d.data_ce = count_q.data_ce + CountWidth'(1);
    if (any_err.data_ue) count_d.data_ue = count_q.data_ue + CountWidth'(1);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      count_q <= '0;
    end else begin
      count_q <= count_d;
    end
  end

  assign err_count_o = count_q;

  // pulse in the same cycle as the failing read
  assign error_inc_o = any_err.tag_ue | any_err.data_ue;

endmodule

// ==== rtl/way_check.sv ====
`timescale 1ns/100ps

module way_check import tag_cmp_pkg::*; (
  input  sram_line_t          rd_line_i,
  input  logic [TagWidth-1:0] sel_tag_i,
  output line_t               line_o,
  output logic                hit_o,
  output ecc_err_t            err_o
);

  logic [TagWidth-1:0] tag_fixed;
  logic [1:0]          tag_err;
  logic                data_ce;
  logic                data_ue;

  // --------------------------------------------------
  // decode tag and blocks
  // --------------------------------------------------
  always_comb begin
    logic [1:0] blk_err;
    data_ce      = 1'b0;
    data_ue      = 1'b0;
    tag_fixed    = ecc_decode_tag(rd_line_i.tag, tag_err);
    line_o.valid = rd_line_i.valid;
    line_o.tag   = tag_fixed;
    for (int b = 0; b < NumBlocks; b++) begin
      line_o.data[b*BlockWidth +: BlockWidth] = ecc_decode_block(rd_line_i.data[b], blk_err);
      data_ce = data_ce | blk_err[0];
      data_ue = data_ue | blk_err[1];
    end
  end

  // invalid lines hold no checked content
  assign err_o.tag_ce  = rd_line_i.valid & tag_err[0];
  assign err_o.tag_ue  = rd_line_i.valid & tag_err[1];
  assign err_o.data_ce = rd_line_i.valid & data_ce;
  assign err_o.data_ue = rd_line_i.valid & data_ue;

  // compare against the corrected tag, a broken tag never hits
  assign hit_o = rd_line_i.valid & ~tag_err[1] & (tag_fixed == sel_tag_i);

endmodule

// ==== rtl/req_arbiter.sv ====
`timescale 1ns/100ps

module req_arbiter import tag_cmp_pkg::*; (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  port_req_t [NumPorts-1:0]          req_i,
  input  logic [NumPorts-1:0][TagWidth-1:0] tag_i,
  input  line_t [NumWays-1:0]               loaded_i,
  output logic [NumPorts-1:0]               gnt_o,
  output sram_req_t                         sram_req_o,
  output logic [TagWidth-1:0]               sel_tag_o
);

  typedef enum logic {
    StNormal,
    StStore
  } state_e;

  state_e              state_d, state_q;
  logic [NumPorts-1:0] id_d, id_q;
  logic [NumPorts-1:0] req_any;
  logic [NumPorts-1:0] win_oh;
  logic [NumPorts-1:0] partial;
  port_req_t           sel_req;
  port_req_t           buf_q;
  logic                buf_load;
  line_t               sel_loaded;
  line_t               merged;
  line_t               to_store;

  // --------------------------------------------------
  // request side
  // --------------------------------------------------
  // a partial write has a block with mixed byte enables
  always_comb begin
    logic [BytesPerBlock-1:0] blk_be;
    for (int p = 0; p < NumPorts; p++) begin
      req_any[p] = |req_i[p].req;
      partial[p] = 1'b0;
      for (int b = 0; b < NumBlocks; b++) begin
        blk_be = req_i[p].be.data[b*BytesPerBlock +: BytesPerBlock];
        if (blk_be != '0 && blk_be != '1) partial[p] = 1'b1;
      end
      partial[p] = partial[p] & req_i[p].we & req_any[p];
    end
  end

  // lowest port index wins
  assign win_oh = req_any & ~(req_any - 1'b1);

  always_comb begin
    sel_req = '0;
    for (int p = 0; p < NumPorts; p++) begin
      if (win_oh[p]) sel_req = req_i[p];
    end
  end

  // tag of the granted port arrives one cycle later
  always_comb begin
    sel_tag_o = '0;
    for (int p = 0; p < NumPorts; p++) begin
      if (id_q[p]) sel_tag_o = tag_i[p];
    end
  end

  // --------------------------------------------------
  // read-modify-write merge
  // --------------------------------------------------
  // first requested way supplies the stored line
  always_comb begin
    sel_loaded = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (buf_q.req[w]) sel_loaded = loaded_i[w];
    end
  end

  always_comb begin
    merged = sel_loaded;
    if (buf_q.be.tag) begin
      merged.valid = buf_q.wdata.valid;
      merged.tag   = buf_q.wdata.tag;
    end
    for (int k = 0; k < NumBlocks * BytesPerBlock; k++) begin
      if (buf_q.be.data[k]) merged.data[k*8 +: 8] = buf_q.wdata.data[k*8 +: 8];
    end
  end

  // --------------------------------------------------
  // memory request and grant
  // --------------------------------------------------
  always_comb begin
    state_d    = state_q;
    id_d       = id_q;
    gnt_o      = '0;
    buf_load   = 1'b0;
    to_store   = merged;
    sram_req_o = '0;
    if (state_q == StNormal) begin
      id_d               = win_oh;
      to_store           = sel_req.wdata;
      sram_req_o.req     = sel_req.req;
      sram_req_o.index   = sel_req.index;
      sram_req_o.be_tag  = sel_req.be.tag;
      for (int b = 0; b < NumBlocks; b++) begin
        sram_req_o.be_data[b] = |sel_req.be.data[b*BytesPerBlock +: BytesPerBlock];
      end
      if (|(win_oh & partial)) begin
        // read the old line now, write it back next cycle
        state_d  = StStore;
        buf_load = 1'b1;
      end else begin
        sram_req_o.we = sel_req.we;
        gnt_o         = win_oh;
      end
    end else begin
      state_d            = StNormal;
      gnt_o              = id_q;
      sram_req_o.req     = buf_q.req;
      sram_req_o.index   = buf_q.index;
      sram_req_o.we      = 1'b1;
      sram_req_o.be_data = '1;
      sram_req_o.be_tag  = 1'b1;
    end
    sram_req_o.wdata.valid = to_store.valid;
    sram_req_o.wdata.tag   = ecc_encode_tag(to_store.tag);
    for (int b = 0; b < NumBlocks; b++) begin
      sram_req_o.wdata.data[b] = ecc_encode_block(to_store.data[b*BlockWidth +: BlockWidth]);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= StNormal;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      id_q    <= id_d;
    end
  end

  // write buffer, loaded on the read cycle of a partial write
  always_ff @(posedge clk_i) begin
    if (buf_load) buf_q <= sel_req;
  end

endmodule

// ==== rtl/tag_cmp_pkg.sv ====
package tag_cmp_pkg;

  // --------------------------------------------------
  // cache geometry
  // --------------------------------------------------
  localparam int unsigned NumPorts      = 2;
  localparam int unsigned NumWays       = 4;
  localparam int unsigned IndexWidth    = 4;
  localparam int unsigned TagWidth      = 20;
  localparam int unsigned TagEccWidth   = 26;
  localparam int unsigned BlockWidth    = 32;
  localparam int unsigned BlockEccWidth = 39;
  localparam int unsigned NumBlocks     = 2;
  localparam int unsigned LineWidth     = 64;
  localparam int unsigned BytesPerBlock = 4;
  localparam int unsigned CountWidth    = 32;
  // enough syndrome bits for the widest codeword
  localparam int unsigned SynWidth      = $clog2(BlockEccWidth);

  typedef struct packed {
    logic                 valid;
    logic [TagWidth-1:0]  tag;
    logic [LineWidth-1:0] data;
  } line_t;

  typedef struct packed {
    logic                                    valid;
    logic [TagEccWidth-1:0]                  tag;
    logic [NumBlocks-1:0][BlockEccWidth-1:0] data;
  } sram_line_t;

  typedef struct packed {
    logic                               tag;
    logic [NumBlocks*BytesPerBlock-1:0] data;
  } line_be_t;

  typedef struct packed {
    logic [NumWays-1:0]    req;
    logic [IndexWidth-1:0] index;
    logic                  we;
    line_t                 wdata;
    line_be_t              be;
  } port_req_t;

  // whole encoded words are written, so one enable per block
  typedef struct packed {
    logic [NumWays-1:0]    req;
    logic [IndexWidth-1:0] index;
    logic                  we;
    sram_line_t            wdata;
    logic [NumBlocks-1:0]  be_data;
    logic                  be_tag;
  } sram_req_t;

  typedef struct packed {
    logic tag_ce;
    logic tag_ue;
    logic data_ce;
    logic data_ue;
  } ecc_err_t;

  typedef struct packed {
    logic [CountWidth-1:0] tag_ce;
    logic [CountWidth-1:0] tag_ue;
    logic [CountWidth-1:0] data_ce;
    logic [CountWidth-1:0] data_ue;
  } err_count_t;

  // --------------------------------------------------
  // extended hamming code
  // --------------------------------------------------
  // bit 0 is overall parity, bits 1..n-1 follow hamming positions
  function automatic logic [BlockEccWidth-1:0] secded_encode(
    input logic [BlockWidth-1:0] raw,
    input int unsigned           n
  );
    logic [BlockEccWidth-1:0] cw;
    logic                     par;
    int unsigned              d;
    cw = '0;
    d  = 0;
    for (int unsigned p = 1; p < BlockEccWidth; p++) begin
      if (p < n && (p & (p - 1)) != 0) begin
        cw[p] = raw[d];
        d++;
      end
    end
    for (int unsigned j = 0; j < SynWidth; j++) begin
      par = 1'b0;
      for (int unsigned p = 1; p < BlockEccWidth; p++) begin
        if (p < n && ((p >> j) & 1) != 0) par ^= cw[p];
      end
      if ((1 << j) < n) cw[1 << j] = par;
    end
    cw[0] = ^cw;
    return cw;
  endfunction

  // err[0] corrected, err[1] uncorrectable
  function automatic logic [BlockWidth-1:0] secded_decode(
    input  logic [BlockEccWidth-1:0] cw_in,
    input  int unsigned              n,
    output logic [1:0]               err
  );
    logic [BlockEccWidth-1:0] cw;
    logic [SynWidth-1:0]      syn;
    logic [BlockWidth-1:0]    raw;
    int unsigned              d;
    cw  = cw_in;
    syn = '0;
    raw = '0;
    d   = 0;
    err = 2'b00;
    for (int unsigned p = 1; p < BlockEccWidth; p++) begin
      if (p < n && cw[p]) syn ^= SynWidth'(p);
    end
    if (^cw) begin
      // odd weight means a single flip, syn points at it
      if (syn < n) begin
        cw[syn] = ~cw[syn];
        err[0]  = 1'b1;
      end else begin
        err[1] = 1'b1;
      end
    end else if (syn != '0) begin
      err[1] = 1'b1;
    end
    for (int unsigned p = 1; p < BlockEccWidth; p++) begin
      if (p < n && (p & (p - 1)) != 0) begin
        raw[d] = cw[p];
        d++;
      end
    end
    return raw;
  endfunction

  function automatic logic [TagEccWidth-1:0] ecc_encode_tag(
    input logic [TagWidth-1:0] tag
  );
    return TagEccWidth'(secded_encode(BlockWidth'(tag), TagEccWidth));
  endfunction

  function automatic logic [BlockEccWidth-1:0] ecc_encode_block(
    input logic [BlockWidth-1:0] blk
  );
    return secded_encode(blk, BlockEccWidth);
  endfunction

  function automatic logic [TagWidth-1:0] ecc_decode_tag(
    input  logic [TagEccWidth-1:0] cw,
    output logic [1:0]             err
  );
    return TagWidth'(secded_decode(BlockEccWidth'(cw), TagEccWidth, err));
  endfunction

  function automatic logic [BlockWidth-1:0] ecc_decode_block(
    input  logic [BlockEccWidth-1:0] cw,
    output logic [1:0]               err
  );
    return secded_decode(cw, BlockEccWidth, err);
  endfunction

endpackage
